//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN      = 32;
    localparam int REG_IDX_W = 5;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // bit positions of the instruction fields
    localparam int OPC_LSB   = 0;
    localparam int RD_LSB    = 7;
    localparam int F3_LSB    = 12;
    localparam int RS1_LSB   = 15;
    localparam int RS2_LSB   = 20;
    localparam int F7_LSB    = 25;
    localparam int IMM_I_LSB = 20; // imm[11:0] of the I-type format
    localparam int IMM_U_LSB = 12; // imm[31:12] of the U-type format

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101; // SRL or SRA, told apart by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000; // selects SUB and SRA

endpackage

`default_nettype wire

//--- rtl/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

    typedef logic [rv_isa_pkg::XLEN-1:0] word_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B // result is the second operand, used by LUI
    } alu_op_t;

    typedef enum logic {
        REG,
        IMM
    } op2_src_t;

    // where a source operand comes from in the execute stage
    typedef enum logic [1:0] {
        REGFILE,
        EX,
        WB
    } bypass_sel_t;

endpackage

`default_nettype wire

//--- rtl/rv_decode.sv
`default_nettype none

module rv_decode
#(
    parameter int NUM_REGS = 32
)
(
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire                    i_instr_valid,
    input  wire [31:0]             i_instr,
    output logic                   o_valid,
    output logic                   o_illegal,
    output rv_isa_pkg::reg_idx_t   o_rs1,
    output rv_isa_pkg::reg_idx_t   o_rs2,
    output rv_isa_pkg::reg_idx_t   o_rd,
    output rv_pipe_pkg::word_t     o_imm,
    output rv_pipe_pkg::alu_op_t   o_alu_op,
    output rv_pipe_pkg::op2_src_t  o_op2_src,
    output logic                   o_reg_write
);

    // the alt bit only matters for the add/sub and shift-right groups
    function automatic rv_pipe_pkg::alu_op_t f3_to_op(input logic [2:0] f3, input logic alt);
        rv_pipe_pkg::alu_op_t op;
        op = rv_pipe_pkg::ADD;
        case (f3)
            rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_pipe_pkg::SUB : rv_pipe_pkg::ADD;
            rv_isa_pkg::F3_SLL:     op = rv_pipe_pkg::SLL;
            rv_isa_pkg::F3_SLT:     op = rv_pipe_pkg::SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_pipe_pkg::SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_pipe_pkg::XOR;
            rv_isa_pkg::F3_SR:      op = alt ? rv_pipe_pkg::SRA : rv_pipe_pkg::SRL;
            rv_isa_pkg::F3_OR:      op = rv_pipe_pkg::OR;
            rv_isa_pkg::F3_AND:     op = rv_pipe_pkg::AND;
        endcase
        return op;
    endfunction

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    rv_isa_pkg::reg_idx_t  rs1, rs2, rd;
    rv_pipe_pkg::word_t    imm_i, imm_u, imm;
    rv_pipe_pkg::alu_op_t  alu_op;
    rv_pipe_pkg::op2_src_t op2_src;
    logic                  enc_ok, idx_ok, legal;
    logic                  uses_rs1, uses_rs2;

    assign opcode = i_instr[rv_isa_pkg::OPC_LSB +: 7];
    assign funct3 = i_instr[rv_isa_pkg::F3_LSB +: 3];
    assign funct7 = i_instr[rv_isa_pkg::F7_LSB +: 7];
    assign rs1    = i_instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_IDX_W];
    assign rs2    = i_instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_IDX_W];
    assign rd     = i_instr[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_IDX_W];
    assign imm_i  = {{20{i_instr[31]}}, i_instr[rv_isa_pkg::IMM_I_LSB +: 12]};
    assign imm_u  = {i_instr[rv_isa_pkg::IMM_U_LSB +: 20], 12'b0};

    always_comb
    begin
        enc_ok   = 1'b0;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        alu_op   = rv_pipe_pkg::ADD;
        op2_src  = rv_pipe_pkg::REG;
        imm      = imm_i;
        case (opcode)
            rv_isa_pkg::OPC_OP:
            begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                enc_ok   = (funct7 == rv_isa_pkg::F7_BASE) ||
                           (funct7 == rv_isa_pkg::F7_ALT &&
                            (funct3 == rv_isa_pkg::F3_ADD_SUB || funct3 == rv_isa_pkg::F3_SR));
                alu_op   = f3_to_op(funct3, funct7 == rv_isa_pkg::F7_ALT);
            end
            rv_isa_pkg::OPC_OP_IMM:
            begin
                uses_rs1 = 1'b1;
                op2_src  = rv_pipe_pkg::IMM;
                alu_op   = f3_to_op(funct3,
                                    funct3 == rv_isa_pkg::F3_SR && funct7 == rv_isa_pkg::F7_ALT);
                if (funct3 == rv_isa_pkg::F3_SLL)
                    enc_ok = funct7 == rv_isa_pkg::F7_BASE;
                else if (funct3 == rv_isa_pkg::F3_SR)
                    enc_ok = funct7 == rv_isa_pkg::F7_BASE || funct7 == rv_isa_pkg::F7_ALT;
                else
                    enc_ok = 1'b1; // the remaining I-type ops take any immediate
            end
            rv_isa_pkg::OPC_LUI:
            begin
                enc_ok  = 1'b1;
                op2_src = rv_pipe_pkg::IMM;
                imm     = imm_u;
                alu_op  = rv_pipe_pkg::PASS_B;
            end
            default: ;
        endcase
    end

    // RV32E has no registers above x15
    assign idx_ok = int'(rd) < NUM_REGS &&
                    (!uses_rs1 || int'(rs1) < NUM_REGS) &&
                    (!uses_rs2 || int'(rs2) < NUM_REGS);
    assign legal  = enc_ok && idx_ok;

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid     <= 1'b0;
            o_illegal   <= 1'b0;
            o_reg_write <= 1'b0;
        end
        else
        begin
            o_valid     <= i_instr_valid && legal;
            o_illegal   <= i_instr_valid && !legal;
            o_reg_write <= legal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rs1     <= rs1;
        o_rs2     <= rs2;
        o_rd      <= rd;
        o_imm     <= imm;
        o_alu_op  <= alu_op;
        o_op2_src <= op2_src;
    end

    a_valid_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(i_instr_valid))
        else $error("instruction valid strobe is unknown");

endmodule

`default_nettype wire

//--- rtl/rv_regs.sv
`default_nettype none

module rv_regs
#(
    parameter int NUM_REGS = 32
)
(
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire rv_isa_pkg::reg_idx_t  i_rs1,
    input  wire rv_isa_pkg::reg_idx_t  i_rs2,
    input  wire                        i_we,
    input  wire rv_isa_pkg::reg_idx_t  i_rd,
    input  wire rv_pipe_pkg::word_t    i_wdata,
    output rv_pipe_pkg::word_t         o_rdata1,
    output rv_pipe_pkg::word_t         o_rdata2
);

    rv_pipe_pkg::word_t regs [NUM_REGS];

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            for (int i = 0; i < NUM_REGS; i++)
                regs[i] <= '0;
        end
        else if (i_we && int'(i_rd) < NUM_REGS)
        begin
            regs[i_rd] <= i_wdata;
        end
    end

    // x0 is hardwired, indices past the array read as zero too
    always_comb
    begin
        o_rdata1 = '0;
        o_rdata2 = '0;
        if (i_rs1 != '0 && int'(i_rs1) < NUM_REGS)
            o_rdata1 = regs[i_rs1];
        if (i_rs2 != '0 && int'(i_rs2) < NUM_REGS)
            o_rdata2 = regs[i_rs2];
    end

endmodule

`default_nettype wire

//--- rtl/rv_operand_bypass.sv
`default_nettype none

module rv_operand_bypass
(
    input  wire rv_isa_pkg::reg_idx_t  i_rs,
    input  wire rv_pipe_pkg::word_t    i_reg_data,
    input  wire rv_isa_pkg::reg_idx_t  i_ex_rd,
    input  wire                        i_ex_we,
    input  wire rv_pipe_pkg::word_t    i_ex_data,
    input  wire rv_isa_pkg::reg_idx_t  i_wb_rd,
    input  wire                        i_wb_we,
    input  wire rv_pipe_pkg::word_t    i_wb_data,
    output rv_pipe_pkg::word_t         o_data
);

    rv_pipe_pkg::bypass_sel_t sel;

    // the younger producer in EX takes priority over WB
    always_comb
    begin
        sel = rv_pipe_pkg::REGFILE;
        if (i_rs != '0 && i_ex_we && i_ex_rd == i_rs)
            sel = rv_pipe_pkg::EX;
        else if (i_rs != '0 && i_wb_we && i_wb_rd == i_rs)
            sel = rv_pipe_pkg::WB;
    end

    always_comb
    begin
        case (sel)
            rv_pipe_pkg::EX: o_data = i_ex_data;
            rv_pipe_pkg::WB: o_data = i_wb_data;
            default:         o_data = i_reg_data;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/rv_alu.sv
`default_nettype none

module rv_alu
(
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_valid,
    input  wire                         i_illegal,
    input  wire rv_isa_pkg::reg_idx_t   i_rd,
    input  wire rv_pipe_pkg::word_t     i_imm,
    input  wire rv_pipe_pkg::alu_op_t   i_alu_op,
    input  wire rv_pipe_pkg::op2_src_t  i_op2_src,
    input  wire                         i_reg_write,
    input  wire rv_pipe_pkg::word_t     i_op1,
    input  wire rv_pipe_pkg::word_t     i_op2,
    output logic                        o_valid,
    output logic                        o_illegal,
    output logic                        o_we,
    output rv_isa_pkg::reg_idx_t        o_rd,
    output rv_pipe_pkg::word_t          o_result
);

    rv_pipe_pkg::word_t op_a;
    rv_pipe_pkg::word_t op_b;
    rv_pipe_pkg::word_t result;
    logic [4:0]         shamt;

    assign op_a  = i_op1;
    assign op_b  = (i_op2_src == rv_pipe_pkg::IMM) ? i_imm : i_op2;
    assign shamt = op_b[4:0]; // also the shamt field of SLLI, SRLI and SRAI

    always_comb
    begin
        case (i_alu_op)
            rv_pipe_pkg::ADD:    result = op_a + op_b;
            rv_pipe_pkg::SUB:    result = op_a - op_b;
            rv_pipe_pkg::SLL:    result = op_a << shamt;
            rv_pipe_pkg::SLT:    result = rv_pipe_pkg::word_t'($signed(op_a) < $signed(op_b));
            rv_pipe_pkg::SLTU:   result = rv_pipe_pkg::word_t'(op_a < op_b);
            rv_pipe_pkg::XOR:    result = op_a ^ op_b;
            rv_pipe_pkg::SRL:    result = op_a >> shamt;
            rv_pipe_pkg::SRA:    result = rv_pipe_pkg::word_t'($signed(op_a) >>> shamt);
            rv_pipe_pkg::OR:     result = op_a | op_b;
            rv_pipe_pkg::AND:    result = op_a & op_b;
            rv_pipe_pkg::PASS_B: result = op_b;
            default:             result = '0;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_valid   <= 1'b0;
            o_illegal <= 1'b0;
            o_we      <= 1'b0;
        end
        else
        begin
            o_valid   <= i_valid;
            o_illegal <= i_illegal;
            o_we      <= i_reg_write && i_valid; // bubbles never write
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rd     <= i_rd;
        o_result <= result;
    end

endmodule

`default_nettype wire

//--- rtl/rv_writeback.sv
`default_nettype none

module rv_writeback
(
    input  wire                        i_clk,
    input  wire                        i_rst,
    input  wire                        i_valid,
    input  wire                        i_illegal,
    input  wire                        i_we,
    input  wire rv_isa_pkg::reg_idx_t  i_rd,
    input  wire rv_pipe_pkg::word_t    i_result,
    output logic                       o_we,
    output rv_isa_pkg::reg_idx_t       o_rd,
    output rv_pipe_pkg::word_t         o_data,
    output logic                       o_retire_valid,
    output logic                       o_illegal
);

    always_ff @(posedge i_clk)
    begin
        if (i_rst)
        begin
            o_we           <= 1'b0;
            o_retire_valid <= 1'b0;
            o_illegal      <= 1'b0;
        end
        else
        begin
            o_we           <= i_we && i_rd != '0; // writes to x0 still retire
            o_retire_valid <= i_valid;
            o_illegal      <= i_illegal;
        end
    end

    always_ff @(posedge i_clk)
    begin
        o_rd   <= i_rd;
        o_data <= i_result;
    end

    // only a retiring instruction may reach the register file
    a_we_retires: assert property (@(posedge i_clk) disable iff (i_rst)
        o_we |-> o_retire_valid)
        else $error("register write without a retiring instruction");

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
`default_nettype none

module rv_core
#(
    parameter int NUM_REGS = 32 // 16 for RV32E
)
(
    input  wire                   i_clk,
    input  wire                   i_rst,
    input  wire                   i_instr_valid,
    input  wire [31:0]            i_instr,
    output logic                  o_retire_valid,
    output rv_isa_pkg::reg_idx_t  o_retire_rd,
    output rv_pipe_pkg::word_t    o_retire_data,
    output logic                  o_illegal
);

    logic                  d_valid, d_illegal, d_reg_write;
    rv_isa_pkg::reg_idx_t  d_rs1, d_rs2, d_rd;
    rv_pipe_pkg::word_t    d_imm;
    rv_pipe_pkg::alu_op_t  d_alu_op;
    rv_pipe_pkg::op2_src_t d_op2_src;

    rv_decode
    #(
        .NUM_REGS       (NUM_REGS)
    )
    u_decode
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_valid        (d_valid),
        .o_illegal      (d_illegal),
        .o_rs1          (d_rs1),
        .o_rs2          (d_rs2),
        .o_rd           (d_rd),
        .o_imm          (d_imm),
        .o_alu_op       (d_alu_op),
        .o_op2_src      (d_op2_src),
        .o_reg_write    (d_reg_write)
    );

    rv_isa_pkg::reg_idx_t src_idx [2];
    rv_pipe_pkg::word_t   src_reg [2];
    rv_pipe_pkg::word_t   src_fwd [2];

    logic                 ex_valid, ex_illegal, ex_we;
    rv_isa_pkg::reg_idx_t ex_rd;
    rv_pipe_pkg::word_t   ex_result;

    logic                 wb_we;
    rv_isa_pkg::reg_idx_t wb_rd;
    rv_pipe_pkg::word_t   wb_data;

    assign src_idx[0] = d_rs1;
    assign src_idx[1] = d_rs2;

    rv_regs
    #(
        .NUM_REGS       (NUM_REGS)
    )
    u_regs
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_rs1          (d_rs1),
        .i_rs2          (d_rs2),
        .i_we           (wb_we),
        .i_rd           (wb_rd),
        .i_wdata        (wb_data),
        .o_rdata1       (src_reg[0]),
        .o_rdata2       (src_reg[1])
    );

    // one forwarding unit per source operand
    for (genvar s = 0; s < 2; s++)
    begin : g_bypass
        rv_operand_bypass u_bypass
        (
            .i_rs       (src_idx[s]),
            .i_reg_data (src_reg[s]),
            .i_ex_rd    (ex_rd),
            .i_ex_we    (ex_we),
            .i_ex_data  (ex_result),
            .i_wb_rd    (wb_rd),
            .i_wb_we    (wb_we),
            .i_wb_data  (wb_data),
            .o_data     (src_fwd[s])
        );
    end

    rv_alu u_alu
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (d_valid),
        .i_illegal      (d_illegal),
        .i_rd           (d_rd),
        .i_imm          (d_imm),
        .i_alu_op       (d_alu_op),
        .i_op2_src      (d_op2_src),
        .i_reg_write    (d_reg_write),
        .i_op1          (src_fwd[0]),
        .i_op2          (src_fwd[1]),
        .o_valid        (ex_valid),
        .o_illegal      (ex_illegal),
        .o_we           (ex_we),
        .o_rd           (ex_rd),
        .o_result       (ex_result)
    );

    rv_writeback u_writeback
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_valid        (ex_valid),
        .i_illegal      (ex_illegal),
        .i_we           (ex_we),
        .i_rd           (ex_rd),
        .i_result       (ex_result),
        .o_we           (wb_we),
        .o_rd           (wb_rd),
        .o_data         (wb_data),
        .o_retire_valid (o_retire_valid),
        .o_illegal      (o_illegal)
    );

    assign o_retire_rd   = wb_rd;
    assign o_retire_data = wb_data;

endmodule

`default_nettype wire

//--- verification/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [31:0]          instr;
        logic                 tight; // sent right after the previous entry, no idle cycles
        logic                 illegal;
        rv_isa_pkg::reg_idx_t rd;
        rv_pipe_pkg::word_t   data;
    } entry_t;

    localparam int LATENCY   = 3;
    localparam int DRAIN_MAX = 16;

    logic                 i_clk;
    logic                 i_rst;
    logic                 i_instr_valid;
    logic [31:0]          i_instr;
    logic                 o_retire_valid;
    rv_isa_pkg::reg_idx_t o_retire_rd;
    rv_pipe_pkg::word_t   o_retire_data;
    logic                 o_illegal;

    entry_t      stim [$];
    entry_t      expected_q [$];
    int          sample_q [$];
    int          cycle;
    logic [15:0] lfsr;

    rv_core rv_core_inst
    (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_instr_valid  (i_instr_valid),
        .i_instr        (i_instr),
        .o_retire_valid (o_retire_valid),
        .o_retire_rd    (o_retire_rd),
        .o_retire_data  (o_retire_data),
        .o_illegal      (o_illegal)
    );

    always #4 i_clk = ~i_clk;

    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3,
                                             input rv_isa_pkg::reg_idx_t rd,
                                             input rv_isa_pkg::reg_idx_t rs1,
                                             input rv_isa_pkg::reg_idx_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encode_i(input logic [2:0] f3,
                                             input rv_isa_pkg::reg_idx_t rd,
                                             input rv_isa_pkg::reg_idx_t rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] encode_u(input rv_isa_pkg::reg_idx_t rd,
                                             input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    task automatic draw_gap(output int gap);
        logic [1:0] bits;
        bits = 2'b00;
        for (int i = 0; i < 2; i++)
        begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[0], lfsr[0]};
        end
        gap = int'(bits);
    endtask

    task automatic add_row(input logic [31:0] instr, input logic tight, input logic illegal,
                           input rv_isa_pkg::reg_idx_t rd, input rv_pipe_pkg::word_t data);
        entry_t row;
        row.instr   = instr;
        row.tight   = tight;
        row.illegal = illegal;
        row.rd      = rd;
        row.data    = data;
        stim.push_back(row);
    endtask

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input rv_pipe_pkg::word_t got,
                              input rv_pipe_pkg::word_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0d ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input rv_isa_pkg::reg_idx_t got,
                             input rv_isa_pkg::reg_idx_t exp);
        if (got !== exp)
        begin
            $display("FAILED at %0d ns: %s = x%0d, expected x%0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
        begin
            $display("FAILED at %0d ns: %s = %0d, expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    // inputs are read before this edge's updates, outputs hold the previous edge's values
    always @(posedge i_clk)
    begin : check_retire
        entry_t head;
        int     sampled;
        cycle = cycle + 1;
        if (!i_rst)
        begin
            if (i_instr_valid)
                sample_q.push_back(cycle);
            if (o_retire_valid || o_illegal)
            begin
                if (expected_q.size() == 0 || sample_q.size() == 0)
                begin
                    $display("retire port fired with no instruction outstanding");
                    stop_on_error();
                end
                else
                begin
                    head    = expected_q.pop_front();
                    sampled = sample_q.pop_front();
                    check_count("retire latency", cycle - sampled, LATENCY);
                    check_bit("o_illegal", o_illegal, head.illegal);
                    check_bit("o_retire_valid", o_retire_valid, !head.illegal);
                    if (!head.illegal)
                    begin
                        check_reg("o_retire_rd", o_retire_rd, head.rd);
                        check_word("o_retire_data", o_retire_data, head.data);
                    end
                end
            end
        end
    end

    initial
    begin
        int gap;
        int waited;
        i_clk         = 1'b0;
        i_rst         = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        cycle         = 0;
        lfsr          = 16'd9;

        add_row(encode_i(3'h0, 5'd1, 5'd0, 12'hffb), 1'b0, 1'b0, 5'd1, 32'hffff_fffb);
        add_row(encode_i(3'h0, 5'd2, 5'd0, 12'h123), 1'b0, 1'b0, 5'd2, 32'h0000_0123);
        add_row(encode_u(5'd3, 20'h80000), 1'b0, 1'b0, 5'd3, 32'h8000_0000);
        add_row(encode_r(7'h00, 3'h0, 5'd4, 5'd1, 5'd2), 1'b0, 1'b0, 5'd4, 32'h0000_011e);
        add_row(encode_r(7'h20, 3'h0, 5'd5, 5'd2, 5'd1), 1'b0, 1'b0, 5'd5, 32'h0000_0128);
        add_row(encode_r(7'h00, 3'h1, 5'd6, 5'd2, 5'd2), 1'b0, 1'b0, 5'd6, 32'h0000_0918);
        add_row(encode_r(7'h00, 3'h2, 5'd7, 5'd1, 5'd2), 1'b0, 1'b0, 5'd7, 32'h0000_0001);
        add_row(encode_r(7'h00, 3'h3, 5'd8, 5'd1, 5'd2), 1'b0, 1'b0, 5'd8, 32'h0000_0000);
        add_row(encode_r(7'h00, 3'h4, 5'd9, 5'd1, 5'd2), 1'b0, 1'b0, 5'd9, 32'hffff_fed8);
        add_row(encode_r(7'h00, 3'h5, 5'd10, 5'd3, 5'd2), 1'b0, 1'b0, 5'd10, 32'h1000_0000);
        add_row(encode_r(7'h20, 3'h5, 5'd11, 5'd3, 5'd2), 1'b0, 1'b0, 5'd11, 32'hf000_0000);
        add_row(encode_r(7'h00, 3'h6, 5'd12, 5'd1, 5'd2), 1'b0, 1'b0, 5'd12, 32'hffff_fffb);
        add_row(encode_r(7'h00, 3'h7, 5'd13, 5'd1, 5'd2), 1'b0, 1'b0, 5'd13, 32'h0000_0123);
        add_row(encode_i(3'h2, 5'd14, 5'd1, 12'hffc), 1'b0, 1'b0, 5'd14, 32'h0000_0001);
        add_row(encode_i(3'h3, 5'd15, 5'd2, 12'hfff), 1'b0, 1'b0, 5'd15, 32'h0000_0001);
        add_row(encode_i(3'h4, 5'd16, 5'd2, 12'h0f0), 1'b0, 1'b0, 5'd16, 32'h0000_01d3);
        add_row(encode_i(3'h6, 5'd17, 5'd2, 12'h800), 1'b0, 1'b0, 5'd17, 32'hffff_f923);
        add_row(encode_i(3'h7, 5'd18, 5'd1, 12'h0ff), 1'b0, 1'b0, 5'd18, 32'h0000_00fb);
        add_row(encode_i(3'h1, 5'd19, 5'd2, 12'h008), 1'b0, 1'b0, 5'd19, 32'h0001_2300);
        add_row(encode_i(3'h5, 5'd20, 5'd1, 12'h004), 1'b0, 1'b0, 5'd20, 32'h0fff_ffff);
        add_row(encode_i(3'h5, 5'd21, 5'd1, 12'h401), 1'b0, 1'b0, 5'd21, 32'hffff_fffd);
        add_row(encode_r(7'h00, 3'h2, 5'd22, 5'd3, 5'd2), 1'b0, 1'b0, 5'd22, 32'h0000_0001);
        add_row(encode_r(7'h00, 3'h3, 5'd23, 5'd3, 5'd2), 1'b0, 1'b0, 5'd23, 32'h0000_0000);
        // dependency chains at fixed distances
        add_row(encode_i(3'h0, 5'd24, 5'd0, 12'h100), 1'b0, 1'b0, 5'd24, 32'h0000_0100);
        add_row(encode_i(3'h0, 5'd25, 5'd24, 12'h001), 1'b1, 1'b0, 5'd25, 32'h0000_0101);
        add_row(encode_i(3'h0, 5'd26, 5'd0, 12'h007), 1'b1, 1'b0, 5'd26, 32'h0000_0007);
        add_row(encode_r(7'h00, 3'h0, 5'd27, 5'd24, 5'd25), 1'b1, 1'b0, 5'd27, 32'h0000_0201);
        add_row(encode_r(7'h20, 3'h0, 5'd28, 5'd26, 5'd27), 1'b1, 1'b0, 5'd28, 32'hffff_fe06);
        add_row(encode_i(3'h0, 5'd29, 5'd0, 12'h001), 1'b1, 1'b0, 5'd29, 32'h0000_0001);
        add_row(encode_i(3'h0, 5'd29, 5'd0, 12'h002), 1'b1, 1'b0, 5'd29, 32'h0000_0002);
        add_row(encode_r(7'h00, 3'h0, 5'd30, 5'd29, 5'd29), 1'b1, 1'b0, 5'd30, 32'h0000_0004);
        // x0 is written, then read at distances 1 and 2
        add_row(encode_i(3'h0, 5'd0, 5'd0, 12'h055), 1'b0, 1'b0, 5'd0, 32'h0000_0055);
        add_row(encode_r(7'h00, 3'h0, 5'd31, 5'd0, 5'd0), 1'b1, 1'b0, 5'd31, 32'h0000_0000);
        add_row(encode_i(3'h0, 5'd31, 5'd0, 12'h003), 1'b1, 1'b0, 5'd31, 32'h0000_0003);
        // illegal words name x1, x2 and x3 as rd and must leave them unchanged
        add_row(32'h0000_00ff, 1'b0, 1'b1, 5'd0, 32'h0000_0000);
        add_row(encode_i(3'h0, 5'd7, 5'd1, 12'h000), 1'b1, 1'b0, 5'd7, 32'hffff_fffb);
        add_row(encode_r(7'h20, 3'h4, 5'd2, 5'd1, 5'd1), 1'b1, 1'b1, 5'd0, 32'h0000_0000);
        add_row(32'h0000_2183, 1'b1, 1'b1, 5'd0, 32'h0000_0000);
        add_row(encode_i(3'h0, 5'd8, 5'd2, 12'h000), 1'b1, 1'b0, 5'd8, 32'h0000_0123);
        add_row(encode_i(3'h0, 5'd9, 5'd3, 12'h000), 1'b1, 1'b0, 5'd9, 32'h8000_0000);
        add_row(encode_r(7'h00, 3'h0, 5'd10, 5'd1, 5'd2), 1'b1, 1'b0, 5'd10, 32'h0000_011e);

        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;
        @(posedge i_clk);
        check_bit("o_retire_valid", o_retire_valid, 1'b0);
        check_bit("o_illegal", o_illegal, 1'b0);

        for (int n = 0; n < stim.size(); n++)
        begin
            if (!stim[n].tight)
            begin
                draw_gap(gap);
                repeat (gap)
                begin
                    @(posedge i_clk);
                    i_instr_valid <= 1'b0;
                end
            end
            @(posedge i_clk);
            i_instr_valid <= 1'b1;
            i_instr       <= stim[n].instr;
            expected_q.push_back(stim[n]);
        end
        @(posedge i_clk);
        i_instr_valid <= 1'b0;

        waited = 0;
        while (expected_q.size() != 0)
        begin
            @(posedge i_clk);
            waited++;
            if (waited > DRAIN_MAX)
            begin
                $display("timeout: %0d instructions never retired", expected_q.size());
                stop_on_error();
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/rv_isa_pkg.sv
rtl/rv_pipe_pkg.sv
rtl/rv_decode.sv
rtl/rv_regs.sv
rtl/rv_operand_bypass.sv
rtl/rv_alu.sv
rtl/rv_writeback.sv
rtl/rv_core.sv
verification/rv_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the RV32I pipeline testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rv_core_tb \
    -Mdir obj_dir \
    -f flist.f

# a $fatal in the testbench gives a nonzero exit status
./obj_dir/Vrv_core_tb
